// ==== include/shq_defines.svh ====
// queue count, data width and pool depth of the shared-buffer queue.
`ifndef SHQ_DEFINES_SVH
`define SHQ_DEFINES_SVH

// ====================
// sizing
// ====================

// logical queues that share the pool.
`define SHQ_NUM_QUEUES 4

// width of one stored data word.
`define SHQ_DATA_WIDTH 32

// storage slots in the shared pool.
`define SHQ_POOL_DEPTH 8

`endif

// ==== hdl/shq_store_pkg.sv ====
// storage-side vector types for the data word, slot index, queue id and slot count.
`include "shq_defines.svh"

package shq_store_pkg;

    // ====================
    // storage widths
    // ====================

    // one word as it sits in the pool.
    typedef logic [`SHQ_DATA_WIDTH-1:0] data_t;

    // index of one pool slot.
    typedef logic [$clog2(`SHQ_POOL_DEPTH)-1:0] slot_t;

    // logical queue number.
    typedef logic [$clog2(`SHQ_NUM_QUEUES)-1:0] qid_t;

    // slot count from 0 up to the pool depth inclusive.
    typedef logic [$clog2(`SHQ_POOL_DEPTH+1)-1:0] cnt_t;

endpackage

// ==== hdl/shq_port_pkg.sv ====
// port payload structs for the push beat, the pop beat and the status.
`include "shq_defines.svh"

package shq_port_pkg;

    // ====================
    // port payloads
    // ====================

    // payload of one per-queue push port.
    typedef struct packed {
        shq_store_pkg::data_t data;
    } push_beat_t;

    // payload of the shared output stream.
    typedef struct packed {
        shq_store_pkg::qid_t  qid;  // queue the word was pushed to.
        shq_store_pkg::data_t data;
    } pop_beat_t;

    // status seen from outside.
    typedef struct packed {
        shq_store_pkg::cnt_t         free_count;
        logic [`SHQ_NUM_QUEUES-1:0]  empty;  // one flag per queue.
    } shq_status_t;

endpackage

// ==== hdl/slot_allocator.sv ====
// occupancy bitmap, lowest-free search, alloc, release and free count of the pool.
`timescale 1ns/1ps
`include "shq_defines.svh"

module slot_allocator (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 flush,
    input  logic                 alloc,
    input  logic                 release_en,
    input  shq_store_pkg::slot_t release_slot,
    output logic                 avail,
    output shq_store_pkg::slot_t free_slot,
    output shq_store_pkg::cnt_t  free_count
);
    import shq_store_pkg::*;

    localparam int DEPTH = `SHQ_POOL_DEPTH;

    logic [DEPTH-1:0] occ;       // one bit per slot, set while the slot holds data.
    logic [DEPTH-1:0] occ_next;

    // ====================
    // lowest free slot
    // ====================
    always_comb begin
        free_slot = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (!occ[i]) begin
                free_slot = slot_t'(i);  // last hit is the lowest index.
            end
        end
    end

    assign avail = ~&occ;

    always_comb begin
        occ_next = occ;
        if (alloc) begin
            occ_next[free_slot] = 1'b1;
        end
        if (release_en) begin
            occ_next[release_slot] = 1'b0;  // never the slot being allocated.
        end
    end

    // ====================
    // state
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            occ        <= '0;
            free_count <= cnt_t'(DEPTH);
        end else if (flush) begin
            occ        <= '0;
            free_count <= cnt_t'(DEPTH);
        end else begin
            occ <= occ_next;
            if (alloc && !release_en) begin
                free_count <= free_count - 1'b1;
            end else if (release_en && !alloc) begin
                free_count <= free_count + 1'b1;
            end
        end
    end

endmodule

// ==== hdl/slot_index_fifo.sv ====
// circular FIFO of slot indices that keeps one queue's order.
`timescale 1ns/1ps
`include "shq_defines.svh"

module slot_index_fifo #(
    parameter int DEPTH = `SHQ_POOL_DEPTH
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 flush,
    input  logic                 push,
    input  shq_store_pkg::slot_t push_slot,
    input  logic                 pop,
    output shq_store_pkg::slot_t head_slot,
    output logic                 empty
);
    import shq_store_pkg::*;

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    slot_t          mem [DEPTH];
    logic [PW-1:0]  wr_ptr;
    logic [PW-1:0]  rd_ptr;
    logic [CW-1:0]  count;

    assign head_slot = mem[rd_ptr];
    assign empty     = (count == '0);

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_slot;
        end
    end

    // ====================
    // pointers and count
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither leave it unchanged.
            endcase
        end
    end

endmodule

// ==== hdl/rr_arbiter.sv ====
// round-robin arbiter that holds its grant until accepted.
`timescale 1ns/1ps

module rr_arbiter #(
    parameter int N = 4
) (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         flush,
    input  logic [N-1:0] req,
    input  logic         enable,
    input  logic         accept,
    output logic [N-1:0] grant
);
    localparam int IW = (N > 1) ? $clog2(N) : 1;

    logic [IW-1:0] ptr;         // highest priority position.
    logic [IW-1:0] held_idx;    // winner kept while waiting for accept.
    logic          held_vld;
    logic [IW-1:0] pick_idx;
    logic          pick_vld;
    logic [IW-1:0] win_idx;
    logic          win_vld;

    always_comb begin
        int idx;
        pick_vld = 1'b0;
        pick_idx = ptr;
        for (int i = 0; i < N; i++) begin
            idx = (int'(ptr) + i) % N;
            if (!pick_vld && req[idx]) begin
                pick_vld = 1'b1;
                pick_idx = IW'(idx);
            end
        end
    end

    assign win_vld = (held_vld && req[held_idx]) || pick_vld;
    assign win_idx = (held_vld && req[held_idx]) ? held_idx : pick_idx;

    always_comb begin
        for (int i = 0; i < N; i++) begin
            grant[i] = enable && win_vld && (win_idx == IW'(i));
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr      <= '0;
            held_idx <= '0;
            held_vld <= 1'b0;
        end else if (flush) begin
            ptr      <= '0;
            held_vld <= 1'b0;
        end else if (accept) begin
            ptr      <= (win_idx == IW'(N - 1)) ? '0 : win_idx + 1'b1;
            held_vld <= 1'b0;
        end else if (|grant) begin
            held_idx <= win_idx;  // granted but not taken, so keep it.
            held_vld <= 1'b1;
        end else if (held_vld && !req[held_idx]) begin
            held_vld <= 1'b0;
        end
    end

endmodule

// ==== hdl/pool_buffer.sv ====
// shared slot storage with one write port and one combinational read port.
`timescale 1ns/1ps
`include "shq_defines.svh"

module pool_buffer (
    input  logic                 clk,
    input  logic                 wr_en,
    input  shq_store_pkg::slot_t wr_slot,
    input  shq_store_pkg::data_t wr_data,
    input  shq_store_pkg::slot_t rd_slot,
    output shq_store_pkg::data_t rd_data
);
    import shq_store_pkg::*;

    localparam int DEPTH = `SHQ_POOL_DEPTH;

    data_t mem [DEPTH];

    // ====================
    // write port
    // ====================
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_slot] <= wr_data;  // a free slot is never the one being read.
        end
    end

    // ====================
    // read port
    // ====================
    assign rd_data = mem[rd_slot];

endmodule

// ==== hdl/shared_queue_top.sv ====
// arbiters, slot allocator, index FIFOs and pool of the shared queue.
`timescale 1ns/1ps
`include "shq_defines.svh"

module shared_queue_top (
    input  logic                                           clk,
    input  logic                                           rst_n,
    input  logic                                           flush,
    input  logic [`SHQ_NUM_QUEUES-1:0]                     in_valid,
    input  shq_port_pkg::push_beat_t [`SHQ_NUM_QUEUES-1:0] in_beat,
    output logic [`SHQ_NUM_QUEUES-1:0]                     in_ready,
    output logic                                           out_valid,
    output shq_port_pkg::pop_beat_t                        out_beat,
    input  logic                                           out_ready,
    output shq_port_pkg::shq_status_t                      status
);
    import shq_store_pkg::*;
    import shq_port_pkg::*;

    localparam int NQ = `SHQ_NUM_QUEUES;

    logic [NQ-1:0] push_grant;
    logic [NQ-1:0] pop_grant;
    logic [NQ-1:0] fifo_empty;
    logic          push_accept;
    logic          pop_accept;
    logic          slot_avail;
    slot_t         free_slot;
    cnt_t          free_count;
    slot_t         head_slot [NQ];
    qid_t          push_qid;
    qid_t          pop_qid;
    slot_t         pop_slot;
    data_t         push_data;
    data_t         pool_rd_data;

    // ====================
    // push side
    // ====================
    rr_arbiter #(
        .N(NQ)
    ) u_push_arb (
        .clk    (clk),
        .rst_n  (rst_n),
        .flush  (flush),
        .req    (in_valid),
        .enable (slot_avail && !flush),  // nothing is taken on a flush edge.
        .accept (push_accept),
        .grant  (push_grant)
    );

    assign in_ready    = push_grant;
    assign push_accept = |(push_grant & in_valid);

    always_comb begin
        push_qid = '0;
        for (int q = 0; q < NQ; q++) begin
            if (push_grant[q]) begin
                push_qid = qid_t'(q);
            end
        end
    end

    assign push_data = in_beat[push_qid].data;

    slot_allocator u_alloc (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (flush),
        .alloc        (push_accept),
        .release_en   (pop_accept),
        .release_slot (pop_slot),
        .avail        (slot_avail),
        .free_slot    (free_slot),
        .free_count   (free_count)
    );

    // ====================
    // per-queue order
    // ====================
    for (genvar q = 0; q < NQ; q++) begin : g_queue
        slot_index_fifo #(
            .DEPTH(`SHQ_POOL_DEPTH)
        ) u_idx_fifo (
            .clk       (clk),
            .rst_n     (rst_n),
            .flush     (flush),
            .push      (push_accept && push_grant[q]),
            .push_slot (free_slot),
            .pop       (pop_accept && pop_grant[q]),
            .head_slot (head_slot[q]),
            .empty     (fifo_empty[q])
        );
    end

    // ====================
    // pop side
    // ====================
    rr_arbiter #(
        .N(NQ)
    ) u_pop_arb (
        .clk    (clk),
        .rst_n  (rst_n),
        .flush  (flush),
        .req    (~fifo_empty),
        .enable (!flush),
        .accept (pop_accept),
        .grant  (pop_grant)
    );

    assign out_valid  = |pop_grant;
    assign pop_accept = out_valid && out_ready;

    always_comb begin
        pop_qid = '0;
        for (int q = 0; q < NQ; q++) begin
            if (pop_grant[q]) begin
                pop_qid = qid_t'(q);
            end
        end
    end

    assign pop_slot = head_slot[pop_qid];

    pool_buffer u_pool (
        .clk     (clk),
        .wr_en   (push_accept),
        .wr_slot (free_slot),
        .wr_data (push_data),
        .rd_slot (pop_slot),
        .rd_data (pool_rd_data)
    );

    assign out_beat = '{qid: pop_qid, data: pool_rd_data};
    assign status   = '{free_count: free_count, empty: fifo_empty};

endmodule

// ==== test/tb_clock_gen.sv ====
// testbench clock and reset generator for the shared-buffer queue.
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;  // released away from the active edge.
    end

endmodule

// ==== test/shared_queue_tb.sv ====
// stimulus, per-queue reference model and assertion checks for the shared queue.
`timescale 1ns/1ps
`include "shq_defines.svh"

module shared_queue_tb;
    import shq_store_pkg::*;
    import shq_port_pkg::*;

    localparam int NQ    = `SHQ_NUM_QUEUES;
    localparam int DEPTH = `SHQ_POOL_DEPTH;

    logic                clk;
    logic                rst_n;
    logic                flush;
    logic [NQ-1:0]       in_valid;
    push_beat_t [NQ-1:0] in_beat;
    logic [NQ-1:0]       in_ready;
    logic                out_valid;
    pop_beat_t           out_beat;
    logic                out_ready;
    shq_status_t         status;

    integer        seed = 32'h9310220a;
    data_t         model_q [NQ][$];  // words pushed and not yet popped, per queue.
    data_t         exp_head [NQ];
    logic [NQ-1:0] exp_empty;
    int            held;
    int            wait_cnt [NQ];    // accepts by other queues while this one waits.
    int            pop_ptr;
    logic          pop_wait;
    pop_beat_t     prev_beat;
    logic [NQ-1:0] last_push_acc;
    int            pops_done = 0;
    qid_t          exp_pick;

    tb_clock_gen #(.PERIOD_NS(20), .RESET_CYCLES(2)) u_clk_gen (.clk(clk), .rst_n(rst_n));

    shared_queue_top u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .in_valid  (in_valid),
        .in_beat   (in_beat),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_beat  (out_beat),
        .out_ready (out_ready),
        .status    (status)
    );

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // ====================
    // reference model
    // ====================
    always @(posedge clk or negedge rst_n) begin
        logic [NQ-1:0] push_acc;
        int            held_sum;
        push_acc = in_valid & in_ready;
        if (!rst_n || flush) begin
            for (int q = 0; q < NQ; q++) begin
                model_q[q].delete();
                wait_cnt[q] <= 0;
            end
            pop_ptr       <= 0;
            pop_wait      <= 1'b0;
            last_push_acc <= '0;
        end else begin
            if (out_valid && out_ready) begin
                void'(model_q[out_beat.qid].pop_front());
                pop_ptr   <= (int'(out_beat.qid) + 1) % NQ;
                pops_done <= pops_done + 1;
            end
            for (int q = 0; q < NQ; q++) begin
                if (push_acc[q]) begin
                    model_q[q].push_back(in_beat[q].data);
                end
                wait_cnt[q] <= (push_acc[q] || !in_valid[q]) ? 0 : wait_cnt[q] + int'(|push_acc);
            end
            pop_wait      <= out_valid && !out_ready;
            prev_beat     <= out_beat;
            last_push_acc <= push_acc;
        end
        held_sum = 0;
        for (int q = 0; q < NQ; q++) begin
            exp_empty[q] <= (model_q[q].size() == 0);
            exp_head[q]  <= (model_q[q].size() != 0) ? model_q[q][0] : '0;
            held_sum     += model_q[q].size();
        end
        held <= held_sum;
    end

    // next queue in cyclic order that should win a fresh pop grant.
    always_comb begin
        exp_pick = '0;
        for (int i = NQ - 1; i >= 0; i--) begin
            if (!exp_empty[(pop_ptr + i) % NQ]) begin
                exp_pick = qid_t'((pop_ptr + i) % NQ);
            end
        end
    end

    // ====================
    // checks
    // ====================
    a_push_grant: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(in_ready) && ((in_ready & ~in_valid) == '0))
        else abort_run($sformatf("Mismatch at %0t: in_ready not one-hot within in_valid", $time));
    a_pop_data: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> !exp_empty[out_beat.qid] && out_beat.data == exp_head[out_beat.qid])
        else abort_run($sformatf("Mismatch at %0t: out_beat differs from queue head", $time));
    a_pop_hold: assert property (@(posedge clk) disable iff (!rst_n)
        pop_wait && !flush |-> out_valid && out_beat == prev_beat)
        else abort_run($sformatf("Mismatch at %0t: out_beat changed under back-pressure", $time));
    a_pop_order: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !pop_wait |-> out_beat.qid == exp_pick)
        else abort_run($sformatf("Mismatch at %0t: pop grant out of cyclic order", $time));
    a_free_count: assert property (@(posedge clk) disable iff (!rst_n)
        status.free_count == cnt_t'(DEPTH - held) && status.empty == exp_empty)
        else abort_run($sformatf("Mismatch at %0t: status disagrees with held words", $time));
    a_idle: assert property (@(posedge clk) disable iff (!rst_n)
        &exp_empty |-> !out_valid)
        else abort_run($sformatf("Mismatch at %0t: out_valid high with all queues empty", $time));
    a_pool_full: assert property (@(posedge clk) disable iff (!rst_n)
        held == DEPTH |-> in_ready == '0 && status.free_count == '0)
        else abort_run($sformatf("Mismatch at %0t: push accepted into a full pool", $time));

    for (genvar q = 0; q < NQ; q++) begin : g_push_fair
        a_push_wait: assert property (@(posedge clk) disable iff (!rst_n) wait_cnt[q] <= NQ - 1)
            else abort_run($sformatf("Mismatch at %0t: queue %0d starved on push", $time, q));
    end

    // ====================
    // stimulus
    // ====================
    task automatic drive_cycle(input int push_mode, input int ready_mode);
        int pick;
        @(negedge clk);
        in_valid = in_valid & ~last_push_acc;  // accepted words leave the port.
        pick     = ($random(seed) & 32'h7fff_ffff) % NQ;
        for (int q = 0; q < NQ; q++) begin
            if (!in_valid[q] && (push_mode == 2 || (push_mode == 1 && q == pick))) begin
                in_valid[q]     = 1'b1;
                in_beat[q].data = $random(seed);
            end
        end
        case (ready_mode)
            0:       out_ready = 1'b0;
            1:       out_ready = ($random(seed) & 1) != 0;
            default: out_ready = 1'b1;
        endcase
    endtask

    function automatic bit goal_reached(input int goal);
        case (goal)
            0:       return rst_n;
            1:       return held == DEPTH;
            2:       return pops_done >= 48;
            3:       return pops_done >= 96;
            default: return held == 0 && in_valid == '0;
        endcase
    endfunction

    task automatic run_phase(input int goal, input int push_mode, input int ready_mode,
                             input int limit, input string what);
        int cycles;
        cycles = 0;
        while (!goal_reached(goal)) begin
            if (cycles >= limit) begin
                abort_run($sformatf("Timeout after %0d cycles while %s.", limit, what));
            end
            drive_cycle(push_mode, ready_mode);
            cycles++;
        end
    endtask

    initial begin
        flush     = 1'b0;
        in_valid  = '0;
        in_beat   = '0;
        out_ready = 1'b0;
        run_phase(0, 0, 0, 10, "waiting for reset release");
        run_phase(1, 2, 0, 40, "filling the pool");
        repeat (4) drive_cycle(2, 0);  // every queue keeps pushing into a full pool.
        @(negedge clk);
        flush    = 1'b1;
        in_valid = '0;
        @(negedge clk);
        flush = 1'b0;
        repeat (2) drive_cycle(0, 0);
        run_phase(2, 1, 1, 2000, "running mixed traffic");
        run_phase(3, 2, 1, 2000, "pushing on all queues");
        run_phase(4, 0, 2, 400, "draining the queues");
        repeat (2) drive_cycle(0, 0);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+include
hdl/shq_store_pkg.sv
hdl/shq_port_pkg.sv
hdl/slot_allocator.sv
hdl/slot_index_fifo.sv
hdl/rr_arbiter.sv
hdl/pool_buffer.sv
hdl/shared_queue_top.sv
test/tb_clock_gen.sv
test/shared_queue_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= shared_queue_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

# the run passes only when the pass line shows up in the simulator output.
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
